// File: logic/link_8b9b_pkg.sv
// 8b9b link constants
// Word and sample geometry, buffer sizes and the receive FSM encoding
// shared by the transmitter, receiver, frame store and top level

package link_8b9b_pkg;

	// Line format
	localparam int word_width      = 8;  // Data bits per word, LSB first on the line
	localparam int idle_gap_bits   = 8;  // Minimum high bits between frames

	// Receiver sampling
	localparam int sample_count    = 4;  // Line samples per clock, bit 0 earliest
	localparam int phase_width     = 2;  // Selects one of sample_count phases

	// Buffering
	localparam int tx_fifo_depth   = 16; // Byte entries queued for transmit
	localparam int max_frame_words = 16; // Largest frame the store accepts
	localparam int frame_len_width = 5;  // Holds 0..max_frame_words

	// Receive FSM
	// Start seen in idle, one settle cycle, then word_width shifts and a
	// commit cycle that also samples the separator bit
	typedef enum logic [1:0] {
		rx_idle    = 2'b00, // Armed by enable, watching for the start edge
		rx_once    = 2'b01, // Phase pipeline fills
		rx_receive = 2'b10, // Shifting data bits
		rx_commit  = 2'b11  // Word out, separator decides next state
	} rx_state_t;

endpackage

// File: logic/tx_8b9b.sv
// 8b9b transmitter
// Byte FIFO with a last flag per entry, plus a serializer that sends one
// whole frame at a time: start bit, then byte LSB first and separator,
// one line bit per clock, then an idle gap of at least idle_gap_bits
`timescale 1ns/1ps

module tx_8b9b (
	input  logic                                   clk,
	input  logic                                   sync_reset,
	input  logic [link_8b9b_pkg::word_width-1:0]   tx_data,
	input  logic                                   tx_write, // One-cycle strobe
	input  logic                                   tx_last,  // Byte closes the frame
	output logic                                   tx_full,
	output logic                                   line_out
);

	// FIFO storage, entry is {last, byte}
	logic [link_8b9b_pkg::word_width:0] fifo_mem [link_8b9b_pkg::tx_fifo_depth];
	logic [$clog2(link_8b9b_pkg::tx_fifo_depth)-1:0] wr_ptr;
	logic [$clog2(link_8b9b_pkg::tx_fifo_depth)-1:0] rd_ptr;
	logic [$clog2(link_8b9b_pkg::tx_fifo_depth+1)-1:0] fifo_count;
	logic [$clog2(link_8b9b_pkg::tx_fifo_depth+1)-1:0] last_count; // Whole frames queued
	logic [link_8b9b_pkg::word_width:0] head;
	logic push;
	logic pop;
	logic pop_last;

	// Serializer
	logic sending;
	logic [$clog2(link_8b9b_pkg::word_width+1)-1:0] bit_idx;
	logic [$clog2(link_8b9b_pkg::idle_gap_bits+1)-1:0] gap_count;
	logic [link_8b9b_pkg::word_width-1:0] shift_reg;
	logic cur_last; // Separator for the byte in flight
	logic gap_done;
	logic start_frame;
	logic next_byte;

	assign tx_full  = fifo_count == link_8b9b_pkg::tx_fifo_depth;
	assign push     = tx_write && !tx_full; // Writes while full are dropped
	assign head     = fifo_mem[rd_ptr];
	assign gap_done = gap_count == link_8b9b_pkg::idle_gap_bits;

	// Only start once a complete frame sits in the FIFO, so the bytes
	// behind the start bit are guaranteed to be there back to back
	assign start_frame = !sending && gap_done && (last_count != '0);
	// Separator 0 means the following byte loads in the same cycle
	assign next_byte   = sending && (bit_idx == link_8b9b_pkg::word_width) && !cur_last;
	assign pop         = start_frame || next_byte;
	assign pop_last    = pop && head[link_8b9b_pkg::word_width];

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= {tx_last, tx_data};
		end
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk) begin
		if (sync_reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_count <= '0;
			last_count <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			fifo_count <= fifo_count + push - pop;
			last_count <= last_count + (push && tx_last) - pop_last;
		end
	end

	always_ff @(posedge clk) begin
		if (sync_reset) begin
			sending   <= 1'b0;
			bit_idx   <= '0;
			gap_count <= '0;
			cur_last  <= 1'b0;
			line_out  <= 1'b1; // Idle line is high
		end else if (!sending) begin
			line_out <= 1'b1;
			if (!gap_done) begin
				gap_count <= gap_count + 1'b1;
			end else if (start_frame) begin
				line_out  <= 1'b0; // Start bit
				sending   <= 1'b1;
				bit_idx   <= '0;
				shift_reg <= head[link_8b9b_pkg::word_width-1:0];
				cur_last  <= head[link_8b9b_pkg::word_width];
			end
		end else if (bit_idx != link_8b9b_pkg::word_width) begin
			line_out  <= shift_reg[0]; // LSB first
			shift_reg <= shift_reg >> 1;
			bit_idx   <= bit_idx + 1'b1;
		end else begin
			line_out <= cur_last; // Separator
			if (cur_last) begin
				sending   <= 1'b0;
				gap_count <= '0; // Gap counts from the bit after the separator
			end else begin
				bit_idx   <= '0;
				shift_reg <= head[link_8b9b_pkg::word_width-1:0];
				cur_last  <= head[link_8b9b_pkg::word_width];
			end
		end
	end

endmodule

// File: logic/oversampled_rx_8b9b.sv
// 8b9b receiver for a 4x oversampled SDR ISERDES front end
// Finds the falling start edge among the samples, fixes the sample phase
// one sample after it, then shifts out words and flags the frame end
// from the separator bit
`timescale 1ns/1ps

module oversampled_rx_8b9b (
	input  logic                                      clk,
	input  logic                                      sync_reset,
	input  logic [link_8b9b_pkg::sample_count-1:0]    line_samples, // Bit 0 arrives first
	input  logic                                      enable,
	output logic [link_8b9b_pkg::word_width-1:0]      word_out,
	output logic                                      word_write,
	output logic                                      frame_complete
);

	link_8b9b_pkg::rx_state_t state;

	logic all_high; // Registered, no low sample last cycle
	logic [link_8b9b_pkg::phase_width-1:0] first_low;
	logic [link_8b9b_pkg::phase_width-1:0] start_phase;
	logic [link_8b9b_pkg::phase_width-1:0] phase; // Latched at start
	logic [link_8b9b_pkg::sample_count-1:0] r_samples;
	logic line_bit; // Recovered bit, one per clock
	logic [link_8b9b_pkg::word_width-1:0] shift_reg;
	logic [$clog2(link_8b9b_pkg::word_width)-1:0] bit_count;

	// Index of the earliest low sample, highest index loses
	always_comb begin
		first_low = '0;
		for (int i = link_8b9b_pkg::sample_count - 1; i >= 0; i--) begin
			if (!line_samples[i]) first_low = i[link_8b9b_pkg::phase_width-1:0];
		end
	end

	// Sampling pipeline
	always_ff @(posedge clk) begin
		all_high    <= &line_samples;
		start_phase <= first_low + 1'b1; // One sample later, last index wraps to 0
		r_samples   <= line_samples;
		// Phase 0 is the sample after the wrap and sits a cycle later
		// than the others, so take it live to line all phases up
		line_bit    <= (phase == '0) ? line_samples[0] : r_samples[phase];
	end

	always_ff @(posedge clk) begin
		if (sync_reset) begin
			state          <= link_8b9b_pkg::rx_idle;
			word_write     <= 1'b0;
			frame_complete <= 1'b0;
		end else begin
			word_write     <= 1'b0;
			frame_complete <= 1'b0;
			case (state)
				link_8b9b_pkg::rx_idle: begin
					if (enable && !all_high) begin // Start bit seen
						phase     <= start_phase;
						bit_count <= ($clog2(link_8b9b_pkg::word_width))'(link_8b9b_pkg::word_width - 1);
						state     <= link_8b9b_pkg::rx_once;
					end
				end
				link_8b9b_pkg::rx_once: begin
					state <= link_8b9b_pkg::rx_receive; // line_bit now uses the new phase
				end
				link_8b9b_pkg::rx_receive: begin
					shift_reg <= {line_bit, shift_reg[link_8b9b_pkg::word_width-1:1]};
					bit_count <= bit_count - 1'b1;
					if (bit_count == '0) state <= link_8b9b_pkg::rx_commit;
				end
				link_8b9b_pkg::rx_commit: begin
					word_out   <= shift_reg;
					word_write <= 1'b1;
					bit_count  <= ($clog2(link_8b9b_pkg::word_width))'(link_8b9b_pkg::word_width - 1);
					if (line_bit) begin // Separator 1 ends the frame
						frame_complete <= 1'b1;
						state          <= link_8b9b_pkg::rx_idle;
					end else begin
						state <= link_8b9b_pkg::rx_receive;
					end
				end
				default: state <= link_8b9b_pkg::rx_idle;
			endcase
		end
	end

endmodule

// File: logic/rx_frame_store.sv
// Received frame buffer
// Collects words of one frame, then holds it with its length until the
// reader acknowledges. Frames that overflow or end while one is held are
// dropped whole and counted
`timescale 1ns/1ps

module rx_frame_store (
	input  logic                                         clk,
	input  logic                                         sync_reset,
	input  logic [link_8b9b_pkg::word_width-1:0]         word_in,
	input  logic                                         word_write,
	input  logic                                         frame_complete, // With the final word
	input  logic [link_8b9b_pkg::frame_len_width-1:0]    rd_addr,
	input  logic                                         frame_ack,
	output logic [link_8b9b_pkg::word_width-1:0]         rd_data,
	output logic                                         frame_ready,
	output logic [link_8b9b_pkg::frame_len_width-1:0]    frame_len,
	output logic [7:0]                                   drop_count
);

	logic [link_8b9b_pkg::word_width-1:0] frame_mem [link_8b9b_pkg::max_frame_words];
	logic [link_8b9b_pkg::frame_len_width-1:0] wr_index; // Next free slot
	logic discard;    // Current frame already lost
	logic index_full;
	logic word_fits;

	assign index_full = wr_index == link_8b9b_pkg::max_frame_words;
	// A word is kept only if nothing is held and the frame is still clean
	assign word_fits  = !frame_ready && !discard && !index_full;

	// Memory is a power of two deep, so the low address bits index it
	always_ff @(posedge clk) begin
		if (word_write && word_fits) begin
			frame_mem[wr_index[link_8b9b_pkg::frame_len_width-2:0]] <= word_in;
		end
	end

	// Registered read, out of range reads return zero
	always_ff @(posedge clk) begin
		if (rd_addr < link_8b9b_pkg::max_frame_words) begin
			rd_data <= frame_mem[rd_addr[link_8b9b_pkg::frame_len_width-2:0]];
		end else begin
			rd_data <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (sync_reset) begin
			wr_index    <= '0;
			discard     <= 1'b0;
			frame_ready <= 1'b0;
			drop_count  <= '0;
		end else begin
			if (frame_ack) frame_ready <= 1'b0; // Falls the cycle after ack

			if (word_write) begin
				if (word_fits) begin
					wr_index <= wr_index + 1'b1;
				end else begin
					discard <= 1'b1; // Overflow, or frame arrived while one is held
				end

				if (frame_complete) begin
					// Index restarts for the next frame whatever happens
					wr_index <= '0;
					discard  <= 1'b0;
					if (word_fits) begin
						frame_ready <= 1'b1;
						frame_len   <= wr_index + 1'b1; // Count includes the final word
					end else if (drop_count != 8'hff) begin
						drop_count <= drop_count + 1'b1; // Saturates
					end
				end
			end
		end
	end

endmodule

// File: logic/link_8b9b_top.sv
// 8b9b link top level
// Transmitter, oversampled receiver and frame store. The serial loop
// from line_out back to line_samples is closed outside this block
`timescale 1ns/1ps

module link_8b9b_top (
	input  logic                                         clk,
	input  logic                                         sync_reset,

	// Transmit side
	input  logic [link_8b9b_pkg::word_width-1:0]         tx_data,
	input  logic                                         tx_write,
	input  logic                                         tx_last,
	output logic                                         tx_full,
	output logic                                         line_out,

	// Receive side
	input  logic [link_8b9b_pkg::sample_count-1:0]       line_samples,
	input  logic                                         enable,

	// Frame reader
	input  logic [link_8b9b_pkg::frame_len_width-1:0]    rd_addr,
	output logic [link_8b9b_pkg::word_width-1:0]         rd_data,
	output logic                                         frame_ready,
	output logic [link_8b9b_pkg::frame_len_width-1:0]    frame_len,
	input  logic                                         frame_ack,
	output logic [7:0]                                   drop_count
);

	// Receiver to frame store
	logic [link_8b9b_pkg::word_width-1:0] word_out;
	logic word_write;
	logic frame_complete;

	tx_8b9b u_tx (
		.clk        (clk),
		.sync_reset (sync_reset),
		.tx_data    (tx_data),
		.tx_write   (tx_write),
		.tx_last    (tx_last),
		.tx_full    (tx_full),
		.line_out   (line_out)
	);

	oversampled_rx_8b9b u_rx (
		.clk            (clk),
		.sync_reset     (sync_reset),
		.line_samples   (line_samples),
		.enable         (enable),
		.word_out       (word_out),
		.word_write     (word_write),
		.frame_complete (frame_complete)
	);

	rx_frame_store u_store (
		.clk            (clk),
		.sync_reset     (sync_reset),
		.word_in        (word_out),
		.word_write     (word_write),
		.frame_complete (frame_complete),
		.rd_addr        (rd_addr),
		.frame_ack      (frame_ack),
		.rd_data        (rd_data),
		.frame_ready    (frame_ready),
		.frame_len      (frame_len),
		.drop_count     (drop_count)
	);

endmodule

// File: include/tb_link_8b9b_util.svh
// Testbench helpers for the 8b9b link
// Galois LFSR bit source, reference model of one written frame and the
// value check shared by all compares
`ifndef TB_LINK_8B9B_UTIL_SVH
`define TB_LINK_8B9B_UTIL_SVH

// Expected outcome of one burst of writes
typedef struct packed {
	logic         deliver;   // Shows up at frame_ready
	logic         drop;      // Counted in drop_count
	logic         hold;      // Reader keeps it until hold_release
	logic [1:0]   ack_delay; // Extra clocks before frame_ack
	logic [4:0]   len;
	logic [127:0] data;      // Byte i at bits 8*i
} frame_t;

logic [31:0] lfsr_state = 32'h659d7d12;
int errors = 0;

// One Galois step per bit taken, taps 32 22 2 1
function automatic logic [31:0] random_bits(input int n);
	logic [31:0] value;
	int i;
	value = '0;
	for (i = 0; i < n; i++) begin
		lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
		value = {value[30:0], lfsr_state[0]};
	end
	return value;
endfunction

// Frame ends at the first byte flagged last, FIFO takes at most its depth.
// A disarmed receiver sees nothing, a held store drops and counts it
function automatic frame_t expected_frame(input logic [255:0] bytes, input logic [31:0] lasts,
		input int count, input logic armed, input logic held);
	frame_t f;
	logic ended;
	int i;
	f = '0;
	ended = 1'b0;
	for (i = 0; i < count && i < link_8b9b_pkg::tx_fifo_depth; i++) begin
		if (!ended) begin
			f.data[8*i +: 8] = bytes[8*i +: 8];
			f.len = f.len + 1'b1;
			ended = lasts[i];
		end
	end
	f.deliver = armed && !held;
	f.drop    = armed && held;
	return f;
endfunction

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	if (actual !== expected) begin
		errors++;
		$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
	end
endtask

`endif

// File: sim/tb_link_8b9b.sv
// Testbench for the 8b9b link top level
// Loops line_out back into line_samples with a sub-bit phase offset,
// sends single, random, overfull, held and unarmed frames and checks
// every frame that the store presents
`timescale 1ns/1ps

module tb_link_8b9b;

	logic clk = 1'b0;
	logic sync_reset;
	logic [link_8b9b_pkg::word_width-1:0] tx_data;
	logic tx_write;
	logic tx_last;
	logic tx_full;
	logic line_out;
	logic [link_8b9b_pkg::sample_count-1:0] line_samples;
	logic enable;
	logic [link_8b9b_pkg::frame_len_width-1:0] rd_addr;
	logic [link_8b9b_pkg::word_width-1:0] rd_data;
	logic frame_ready;
	logic [link_8b9b_pkg::frame_len_width-1:0] frame_len;
	logic frame_ack;
	logic [7:0] drop_count;

	`include "tb_link_8b9b_util.svh"

	frame_t expected_q[$];     // Frames the reader should see, in order
	logic [255:0] wr_bytes;    // Current burst
	logic [31:0] wr_last;
	int line_phase = 0;        // Line delay in samples
	int outstanding = 0;       // Delivered but not yet acknowledged
	int drops_expected = 0;
	int frames_checked = 0;
	int line_bits = 0;         // Sets the watchdog budget
	int cycle_count = 0;
	logic hold_release = 1'b0;

	link_8b9b_top dut_i (
		.clk          (clk),
		.sync_reset   (sync_reset),
		.tx_data      (tx_data),
		.tx_write     (tx_write),
		.tx_last      (tx_last),
		.tx_full      (tx_full),
		.line_out     (line_out),
		.line_samples (line_samples),
		.enable       (enable),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.frame_ready  (frame_ready),
		.frame_len    (frame_len),
		.frame_ack    (frame_ack),
		.drop_count   (drop_count)
	);

	always #10 clk = ~clk;

	// Two line bits side by side, the current one shifted line_phase samples late
	initial begin : line_model
		logic [1:0] line_hist;
		logic [7:0] window;
		line_hist    = 2'b11;
		line_samples = 4'hf;
		forever begin
			@(posedge clk);
			#1;
			line_hist    = {line_hist[0], line_out};
			window       = {{4{line_hist[0]}}, {4{line_hist[1]}}}; // Older bit low
			line_samples = window[4 - line_phase +: 4];
		end
	end

	initial begin : watchdog
		while (cycle_count <= 40 * line_bits + 2000) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d clocks, the link stopped delivering frames", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	// Reads each presented frame, compares it with the queue and acknowledges
	initial begin : compare
		frame_t want;
		int i;
		rd_addr   = '0;
		frame_ack = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (frame_ready) begin
				want = '0;
				if (expected_q.size() == 0) begin
					errors++;
					$display("Unexpected frame at %0t with no frame pending", $time);
				end else begin
					want = expected_q.pop_front();
				end
				check_equal(frame_len, want.len, "frame_len");
				for (i = 0; i < want.len; i++) begin
					rd_addr = i[4:0];
					@(posedge clk);
					#1;
					check_equal(rd_data, want.data[8*i +: 8], "frame byte"); // Registered read
				end
				frames_checked++;
				if (want.hold) wait (hold_release);
				repeat (want.ack_delay) begin
					@(posedge clk);
					#1;
				end
				frame_ack = 1'b1;
				@(posedge clk);
				#1;
				frame_ack = 1'b0;
				if (want.deliver) outstanding--;
			end
		end
	end

	task automatic step_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_acked();
		while (outstanding != 0) step_cycles(1);
	endtask

	// len bytes with the last one closing the frame, then extra bytes that
	// each would open and close a frame of their own if the FIFO took them
	task automatic send_frame(input int len, input int extra, input logic hold);
		frame_t f;
		int i;
		for (i = 0; i < len + extra; i++) begin
			wr_bytes[8*i +: 8] = random_bits(8);
			wr_last[i]         = i >= len - 1;
		end
		f = expected_frame(wr_bytes, wr_last, len + extra, enable, outstanding != 0);
		f.hold      = hold;
		f.ack_delay = random_bits(2);
		if (f.deliver) begin
			expected_q.push_back(f);
			outstanding++;
		end
		if (f.drop) drops_expected++;
		line_bits += 1 + 9 * f.len + link_8b9b_pkg::idle_gap_bits;
		for (i = 0; i < len + extra; i++) begin
			if (i == link_8b9b_pkg::tx_fifo_depth) check_equal(tx_full, 1'b1, "tx_full when full");
			tx_data  = wr_bytes[8*i +: 8];
			tx_last  = wr_last[i];
			tx_write = 1'b1;
			step_cycles(1);
		end
		tx_write = 1'b0;
		tx_last  = 1'b0;
	endtask

	initial begin : stimulus
		int n;
		int len;
		int checked_before;
		sync_reset = 1'b1;
		tx_data    = '0;
		tx_write   = 1'b0;
		tx_last    = 1'b0;
		enable     = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		sync_reset = 1'b0;

		check_equal(frame_ready, 1'b0, "frame_ready after reset");
		check_equal(drop_count, 8'd0, "drop_count after reset");
		check_equal(tx_full, 1'b0, "tx_full after reset");
		check_equal(line_out, 1'b1, "line_out after reset");
		enable = 1'b1;
		step_cycles(2);

		for (n = 0; n < 4; n++) begin // One byte at every phase, 3 is the wrapped one
			wait_acked();
			line_phase = n;
			send_frame(1, 0, 1'b0);
		end

		for (n = 0; n < 12; n++) begin
			wait_acked();
			line_phase = random_bits(2); // Line idle here
			len = 2 + random_bits(4) % 15;
			send_frame(len, 0, 1'b0);
		end

		// Sixteen bytes fill the FIFO, the seventeenth is refused
		wait_acked();
		send_frame(16, 1, 1'b0);

		// Second frame ends while the first is still held
		wait_acked();
		checked_before = frames_checked;
		send_frame(1 + random_bits(4), 0, 1'b1);
		while (frames_checked == checked_before) step_cycles(1);
		len = 1 + random_bits(4);
		send_frame(len, 0, 1'b0);
		step_cycles(9 * len + 40);
		check_equal(drop_count, drops_expected, "drop_count after held frame");
		hold_release = 1'b1;
		wait_acked();
		send_frame(1 + random_bits(4), 0, 1'b0);

		// Receiver disarmed, frame passes unseen
		wait_acked();
		enable = 1'b0;
		len = 1 + random_bits(4);
		send_frame(len, 0, 1'b0);
		step_cycles(9 * len + 40);
		check_equal(drop_count, drops_expected, "drop_count while disabled");
		enable = 1'b1;
		step_cycles(2);
		send_frame(2 + random_bits(4) % 15, 0, 1'b0);
		wait_acked();
		step_cycles(40);

		if (expected_q.size() != 0) begin
			errors++;
			$display("%0d expected frames never arrived", expected_q.size());
		end
		$display("Errors %0d, frames checked %0d, frames dropped %0d",
			errors, frames_checked, drop_count);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
logic/link_8b9b_pkg.sv
logic/tx_8b9b.sv
logic/oversampled_rx_8b9b.sv
logic/rx_frame_store.sv
logic/link_8b9b_top.sv
sim/tb_link_8b9b.sv

// File: Makefile
# Verilator lint and simulation of the 8b9b link testbench
# Override on the command line, e.g. make sim TOP=tb_link_8b9b FLAGS="--timing"

VERILATOR ?= verilator
TOP       ?= tb_link_8b9b
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the testbench printed the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
